/* sim.f */
+incdir+verilog
verilog/arb_pkg.sv
verilog/bank_arbiter.sv
verilog/response_merge.sv
verilog/memory_arbiter.sv
test/tb_bank_ram.sv
test/tb_memory_arbiter.sv

/* Bender.yml */
package:
  name: memory_arbiter

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/arb_pkg.sv
      - verilog/bank_arbiter.sv
      - verilog/response_merge.sv
      - verilog/memory_arbiter.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_bank_ram.sv
      - test/tb_memory_arbiter.sv

/* test/tb_memory_arbiter.sv */
`timescale 1ns/100ps

module tb_memory_arbiter;

	localparam int TIMEOUT  = 50; // cycles per wait
	localparam int NUM_RAND = 32;
	localparam int SPRITE   = 0;
	localparam int BG0      = 1;
	localparam int FLASH    = 2;
	localparam int CPU      = 3;

	// readies and wr low, masks all ones, bank addr and din zero
	localparam logic [135:0] RST_VIEW = {16'h00ff, 120'd0};

	logic CLK;
	logic RSTb;

	arb_pkg::addr_t sprite_address, bg0_address, fl_address, cpu_address;
	logic sprite_valid, bg0_valid, fl_valid, cpu_valid;
	logic sprite_ready, bg0_ready, fl_ready, cpu_ready;
	arb_pkg::data_t sprite_data, bg0_data, cpu_data;
	arb_pkg::data_t fl_data, cpu_data_in;
	logic cpu_wr;
	arb_pkg::mask_t cpu_wr_mask;

	arb_pkg::bank_addr_t b1_addr, b2_addr, b3_addr, b4_addr;
	arb_pkg::data_t b1_din, b2_din, b3_din, b4_din;
	arb_pkg::data_t b1_dout, b2_dout, b3_dout, b4_dout;
	arb_pkg::mask_t b1_mask, b2_mask, b3_mask, b4_mask;
	logic b1_wr, b2_wr, b3_wr, b4_wr;

	arb_pkg::data_t ref_mem [0:65535]; // expected memory contents
	arb_pkg::data_t sprite_exp, bg0_exp, cpu_exp;
	logic sprite_chk, bg0_chk, cpu_chk; // read in flight, data is checked
	logic fast;     // each request meets an idle bank
	logic contend;  // sprite and cpu fight for one bank
	logic parallel; // sprite and bg0 on different banks
	logic [31:0] rng;
	int errors;
	int timeouts;
	logic [135:0] rst_view;

	memory_arbiter i_dut (.*);
	tb_bank_ram i_ram (.*);

	assign rst_view = {sprite_ready, bg0_ready, fl_ready, cpu_ready, b1_wr, b2_wr, b3_wr, b4_wr,
		b1_mask, b2_mask, b3_mask, b4_mask, b1_addr, b2_addr, b3_addr, b4_addr,
		b1_din, b2_din, b3_din, b4_din};

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function arb_pkg::data_t random_word();
		rng = xorshift(rng);
		return rng[15:0];
	endfunction

	function automatic arb_pkg::data_t apply_mask(input arb_pkg::data_t old_word,
			input arb_pkg::data_t wdata, input arb_pkg::mask_t m);
		arb_pkg::data_t w;
		w = old_word;
		if (m[0])
			w[7:0] = wdata[7:0]; // low byte
		if (m[1])
			w[15:8] = wdata[15:8];
		return w;
	endfunction

	function void note_mismatch(input string name, input logic [135:0] expected,
			input logic [135:0] actual);
		errors++;
		$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
	endfunction

	function automatic logic ready_of(input int who);
		case (who)
			SPRITE:  return sprite_ready;
			BG0:     return bg0_ready;
			FLASH:   return fl_ready;
			default: return cpu_ready;
		endcase
	endfunction

	// one access, valid held through the edge where ready is high
	task automatic access(input int who, input arb_pkg::addr_t addr, input arb_pkg::data_t wdata,
			input logic wr, input arb_pkg::mask_t m);
		int n;
		n = 0;
		@(negedge CLK);
		case (who)
			SPRITE: begin
				sprite_address = addr;
				sprite_exp     = ref_mem[addr];
				sprite_chk     = 1'b1;
				sprite_valid   = 1'b1;
			end
			BG0: begin
				bg0_address = addr;
				bg0_exp     = ref_mem[addr];
				bg0_chk     = 1'b1;
				bg0_valid   = 1'b1;
			end
			FLASH: begin
				fl_address = addr;
				fl_data    = wdata;
				fl_valid   = 1'b1;
			end
			default: begin
				cpu_address = addr;
				cpu_data_in = wdata;
				cpu_wr      = wr;
				cpu_wr_mask = m;
				cpu_exp     = ref_mem[addr];
				cpu_chk     = !wr;
				cpu_valid   = 1'b1;
			end
		endcase
		do begin
			@(negedge CLK);
			n++;
		end while (!ready_of(who) && n < TIMEOUT);
		if (!ready_of(who)) begin
			timeouts++;
			$display("timeout waiting for ready from requester %0d at address %h", who, addr);
		end
		@(negedge CLK); // transfer on the rising edge before this
		case (who)
			SPRITE: begin
				sprite_valid = 1'b0;
				sprite_chk   = 1'b0;
			end
			BG0: begin
				bg0_valid = 1'b0;
				bg0_chk   = 1'b0;
			end
			FLASH: fl_valid = 1'b0;
			default: begin
				cpu_valid = 1'b0;
				cpu_chk   = 1'b0;
			end
		endcase
		if (who == FLASH)
			ref_mem[addr] = wdata;
		else if (who == CPU && wr)
			ref_mem[addr] = apply_mask(ref_mem[addr], wdata, m);
	endtask

	a_reset: assert property (@(posedge CLK) !RSTb |=> rst_view == RST_VIEW)
		else note_mismatch("rst_view", RST_VIEW, $sampled(rst_view));

	// ready only ever answers a live request
	a_sprite_hold: assert property (@(posedge CLK) disable iff (!RSTb) sprite_ready |-> sprite_valid)
		else note_mismatch("sprite_ready", 0, 1);
	a_bg0_hold: assert property (@(posedge CLK) disable iff (!RSTb) bg0_ready |-> bg0_valid)
		else note_mismatch("bg0_ready", 0, 1);
	a_fl_hold: assert property (@(posedge CLK) disable iff (!RSTb) fl_ready |-> fl_valid)
		else note_mismatch("fl_ready", 0, 1);
	a_cpu_hold: assert property (@(posedge CLK) disable iff (!RSTb) cpu_ready |-> cpu_valid)
		else note_mismatch("cpu_ready", 0, 1);

	// idle bank, ready one cycle after valid
	a_sprite_fast: assert property (@(posedge CLK) disable iff (!RSTb)
		fast && $rose(sprite_valid) |=> sprite_ready)
		else note_mismatch("sprite_ready", 1, $sampled(sprite_ready));
	a_bg0_fast: assert property (@(posedge CLK) disable iff (!RSTb)
		fast && $rose(bg0_valid) |=> bg0_ready)
		else note_mismatch("bg0_ready", 1, $sampled(bg0_ready));
	a_fl_fast: assert property (@(posedge CLK) disable iff (!RSTb)
		fast && $rose(fl_valid) |=> fl_ready)
		else note_mismatch("fl_ready", 1, $sampled(fl_ready));
	a_cpu_fast: assert property (@(posedge CLK) disable iff (!RSTb)
		fast && $rose(cpu_valid) |=> cpu_ready)
		else note_mismatch("cpu_ready", 1, $sampled(cpu_ready));

	a_sprite_data: assert property (@(posedge CLK) disable iff (!RSTb)
		sprite_ready && sprite_chk |-> sprite_data == sprite_exp)
		else note_mismatch("sprite_data", $sampled(sprite_exp), $sampled(sprite_data));
	a_bg0_data: assert property (@(posedge CLK) disable iff (!RSTb)
		bg0_ready && bg0_chk |-> bg0_data == bg0_exp)
		else note_mismatch("bg0_data", $sampled(bg0_exp), $sampled(bg0_data));
	a_cpu_data: assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_ready && cpu_chk |-> cpu_data == cpu_exp)
		else note_mismatch("cpu_data", $sampled(cpu_exp), $sampled(cpu_data));

	// cpu waits until the bank has gone idle after sprite
	a_priority: assert property (@(posedge CLK) disable iff (!RSTb)
		contend && (sprite_valid || $past(sprite_valid)) |-> !cpu_ready)
		else note_mismatch("cpu_ready", 0, 1);
	a_parallel: assert property (@(posedge CLK) disable iff (!RSTb)
		parallel |-> sprite_ready == bg0_ready)
		else note_mismatch("bg0_ready", $sampled(sprite_ready), $sampled(bg0_ready));

	initial begin
		arb_pkg::addr_t rnd_addr [NUM_RAND];
		RSTb           = 1'b0;
		sprite_address = '0;
		bg0_address    = '0;
		fl_address     = '0;
		cpu_address    = '0;
		sprite_valid   = 1'b0;
		bg0_valid      = 1'b0;
		fl_valid       = 1'b0;
		cpu_valid      = 1'b0;
		fl_data        = '0;
		cpu_data_in    = '0;
		cpu_wr         = 1'b0;
		cpu_wr_mask    = 2'b11;
		sprite_chk     = 1'b0;
		bg0_chk        = 1'b0;
		cpu_chk        = 1'b0;
		fast           = 1'b0;
		contend        = 1'b0;
		parallel       = 1'b0;
		rng            = 32'h38a5;
		errors         = 0;
		timeouts       = 0;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;
		fast = 1'b1;

		// one word per bank, flash writes and cpu reads back
		for (int i = 0; i < 4; i++)
			access(FLASH, arb_pkg::addr_t'(16'h0123 + 16'h4444 * i), random_word(), 1'b1, 2'b11);
		for (int i = 0; i < 4; i++)
			access(CPU, arb_pkg::addr_t'(16'h0123 + 16'h4444 * i), '0, 1'b0, 2'b11);

		// byte lanes one at a time over a known word
		access(FLASH, 16'h5a5a, 16'h1234, 1'b1, 2'b11);
		access(CPU, 16'h5a5a, 16'habcd, 1'b1, 2'b01);
		access(CPU, 16'h5a5a, 16'hef77, 1'b1, 2'b10);
		access(SPRITE, 16'h5a5a, '0, 1'b0, 2'b11);
		access(BG0, 16'h5a5a, '0, 1'b0, 2'b11);

		fast    = 1'b0;
		contend = 1'b1;
		fork
			access(SPRITE, 16'hcdef, '0, 1'b0, 2'b11);
			access(CPU, 16'hcdef, '0, 1'b0, 2'b11);
		join
		contend  = 1'b0;
		fast     = 1'b1;
		parallel = 1'b1;
		fork
			access(SPRITE, 16'h0123, '0, 1'b0, 2'b11); // bank 0
			access(BG0, 16'h89ab, '0, 1'b0, 2'b11);    // bank 2
		join
		parallel = 1'b0;

		for (int i = 0; i < NUM_RAND; i++) begin
			rnd_addr[i] = random_word();
			if (random_word() > 16'h7fff)
				access(FLASH, rnd_addr[i], random_word(), 1'b1, 2'b11);
			else
				access(CPU, rnd_addr[i], random_word(), 1'b1, 2'b11);
		end
		for (int i = 0; i < NUM_RAND; i++)
			access(i % 3 == 0 ? SPRITE : (i % 3 == 1 ? BG0 : CPU), rnd_addr[i], '0, 1'b0, 2'b11);

		repeat (2) @(negedge CLK);
		$display("checks done: %0d errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* test/tb_bank_ram.sv */
`timescale 1ns/100ps

`include "arb_params.svh"

module tb_bank_ram (
	input  logic                CLK,

	input  arb_pkg::bank_addr_t b1_addr,
	input  arb_pkg::data_t      b1_din,
	input  arb_pkg::mask_t      b1_mask,
	input  logic                b1_wr,
	output arb_pkg::data_t      b1_dout,

	input  arb_pkg::bank_addr_t b2_addr,
	input  arb_pkg::data_t      b2_din,
	input  arb_pkg::mask_t      b2_mask,
	input  logic                b2_wr,
	output arb_pkg::data_t      b2_dout,

	input  arb_pkg::bank_addr_t b3_addr,
	input  arb_pkg::data_t      b3_din,
	input  arb_pkg::mask_t      b3_mask,
	input  logic                b3_wr,
	output arb_pkg::data_t      b3_dout,

	input  arb_pkg::bank_addr_t b4_addr,
	input  arb_pkg::data_t      b4_din,
	input  arb_pkg::mask_t      b4_mask,
	input  logic                b4_wr,
	output arb_pkg::data_t      b4_dout
);

	localparam int DEPTH = 1 << `ARB_BANK_ADDR_W; // 16K words

	arb_pkg::data_t mem [`ARB_NUM_BANKS][DEPTH];

	// byte lanes, bit 0 low byte
	function automatic arb_pkg::data_t merge_bytes(input arb_pkg::data_t old_word,
			input arb_pkg::data_t new_word, input arb_pkg::mask_t m);
		arb_pkg::data_t w;
		w = old_word;
		if (m[0])
			w[7:0] = new_word[7:0];
		if (m[1])
			w[15:8] = new_word[15:8];
		return w;
	endfunction

	always_ff @(posedge CLK) begin
		if (b1_wr)
			mem[0][b1_addr] <= merge_bytes(mem[0][b1_addr], b1_din, b1_mask);
		if (b2_wr)
			mem[1][b2_addr] <= merge_bytes(mem[1][b2_addr], b2_din, b2_mask);
		if (b3_wr)
			mem[2][b3_addr] <= merge_bytes(mem[2][b3_addr], b3_din, b3_mask);
		if (b4_wr)
			mem[3][b4_addr] <= merge_bytes(mem[3][b4_addr], b4_din, b4_mask);
	end

	// asynchronous read port
	assign b1_dout = mem[0][b1_addr];
	assign b2_dout = mem[1][b2_addr];
	assign b3_dout = mem[2][b3_addr];
	assign b4_dout = mem[3][b4_addr];

endmodule

/* verilog/memory_arbiter.sv */
`timescale 1ns/100ps

module memory_arbiter (
	input  logic                CLK,
	input  logic                RSTb,

	// sprite fetcher, reads
	input  arb_pkg::addr_t      sprite_address,
	input  logic                sprite_valid,
	output arb_pkg::data_t      sprite_data,
	output logic                sprite_ready,

	// background 0 fetcher, reads
	input  arb_pkg::addr_t      bg0_address,
	input  logic                bg0_valid,
	output arb_pkg::data_t      bg0_data,
	output logic                bg0_ready,

	// flash loader, writes
	input  arb_pkg::addr_t      fl_address,
	input  arb_pkg::data_t      fl_data,
	input  logic                fl_valid,
	output logic                fl_ready,

	// cpu
	input  arb_pkg::addr_t      cpu_address,
	input  arb_pkg::data_t      cpu_data_in,
	output arb_pkg::data_t      cpu_data,
	input  logic                cpu_valid,
	input  logic                cpu_wr,
	input  arb_pkg::mask_t      cpu_wr_mask,
	output logic                cpu_ready,

	output arb_pkg::bank_addr_t b1_addr,
	input  arb_pkg::data_t      b1_dout,
	output arb_pkg::data_t      b1_din,
	output arb_pkg::mask_t      b1_mask,
	output logic                b1_wr,

	output arb_pkg::bank_addr_t b2_addr,
	input  arb_pkg::data_t      b2_dout,
	output arb_pkg::data_t      b2_din,
	output arb_pkg::mask_t      b2_mask,
	output logic                b2_wr,

	output arb_pkg::bank_addr_t b3_addr,
	input  arb_pkg::data_t      b3_dout,
	output arb_pkg::data_t      b3_din,
	output arb_pkg::mask_t      b3_mask,
	output logic                b3_wr,

	output arb_pkg::bank_addr_t b4_addr,
	input  arb_pkg::data_t      b4_dout,
	output arb_pkg::data_t      b4_din,
	output arb_pkg::mask_t      b4_mask,
	output logic                b4_wr
);

	arb_pkg::grant_t grant0; // current owner of each bank
	arb_pkg::grant_t grant1;
	arb_pkg::grant_t grant2;
	arb_pkg::grant_t grant3;

	// bank 0 is addresses 0x0000..0x3fff
	bank_arbiter #(.BANK_INDEX(0)) i_bank0 (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.sprite_valid   (sprite_valid),
		.sprite_address (sprite_address),
		.bg0_valid      (bg0_valid),
		.bg0_address    (bg0_address),
		.fl_valid       (fl_valid),
		.fl_address     (fl_address),
		.fl_data        (fl_data),
		.cpu_valid      (cpu_valid),
		.cpu_address    (cpu_address),
		.cpu_wr         (cpu_wr),
		.cpu_wr_mask    (cpu_wr_mask),
		.cpu_data_in    (cpu_data_in),
		.grant          (grant0),
		.mem_addr       (b1_addr),
		.mem_din        (b1_din),
		.mem_mask       (b1_mask),
		.mem_wr         (b1_wr)
	);

	bank_arbiter #(.BANK_INDEX(1)) i_bank1 (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.sprite_valid   (sprite_valid),
		.sprite_address (sprite_address),
		.bg0_valid      (bg0_valid),
		.bg0_address    (bg0_address),
		.fl_valid       (fl_valid),
		.fl_address     (fl_address),
		.fl_data        (fl_data),
		.cpu_valid      (cpu_valid),
		.cpu_address    (cpu_address),
		.cpu_wr         (cpu_wr),
		.cpu_wr_mask    (cpu_wr_mask),
		.cpu_data_in    (cpu_data_in),
		.grant          (grant1),
		.mem_addr       (b2_addr),
		.mem_din        (b2_din),
		.mem_mask       (b2_mask),
		.mem_wr         (b2_wr)
	);

	bank_arbiter #(.BANK_INDEX(2)) i_bank2 (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.sprite_valid   (sprite_valid),
		.sprite_address (sprite_address),
		.bg0_valid      (bg0_valid),
		.bg0_address    (bg0_address),
		.fl_valid       (fl_valid),
		.fl_address     (fl_address),
		.fl_data        (fl_data),
		.cpu_valid      (cpu_valid),
		.cpu_address    (cpu_address),
		.cpu_wr         (cpu_wr),
		.cpu_wr_mask    (cpu_wr_mask),
		.cpu_data_in    (cpu_data_in),
		.grant          (grant2),
		.mem_addr       (b3_addr),
		.mem_din        (b3_din),
		.mem_mask       (b3_mask),
		.mem_wr         (b3_wr)
	);

	// top bank, 0xc000 and up
	bank_arbiter #(.BANK_INDEX(3)) i_bank3 (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.sprite_valid   (sprite_valid),
		.sprite_address (sprite_address),
		.bg0_valid      (bg0_valid),
		.bg0_address    (bg0_address),
		.fl_valid       (fl_valid),
		.fl_address     (fl_address),
		.fl_data        (fl_data),
		.cpu_valid      (cpu_valid),
		.cpu_address    (cpu_address),
		.cpu_wr         (cpu_wr),
		.cpu_wr_mask    (cpu_wr_mask),
		.cpu_data_in    (cpu_data_in),
		.grant          (grant3),
		.mem_addr       (b4_addr),
		.mem_din        (b4_din),
		.mem_mask       (b4_mask),
		.mem_wr         (b4_wr)
	);

	// ready and read data back to the requesters
	response_merge i_merge (
		.grant0       (grant0),
		.grant1       (grant1),
		.grant2       (grant2),
		.grant3       (grant3),
		.dout0        (b1_dout),
		.dout1        (b2_dout),
		.dout2        (b3_dout),
		.dout3        (b4_dout),
		.sprite_valid (sprite_valid),
		.bg0_valid    (bg0_valid),
		.fl_valid     (fl_valid),
		.cpu_valid    (cpu_valid),
		.sprite_ready (sprite_ready),
		.bg0_ready    (bg0_ready),
		.fl_ready     (fl_ready),
		.cpu_ready    (cpu_ready),
		.sprite_data  (sprite_data),
		.bg0_data     (bg0_data),
		.cpu_data     (cpu_data)
	);

endmodule

/* verilog/response_merge.sv */
`timescale 1ns/100ps

`include "arb_params.svh"

module response_merge (
	input  arb_pkg::grant_t grant0,
	input  arb_pkg::grant_t grant1,
	input  arb_pkg::grant_t grant2,
	input  arb_pkg::grant_t grant3,
	input  arb_pkg::data_t  dout0,
	input  arb_pkg::data_t  dout1,
	input  arb_pkg::data_t  dout2,
	input  arb_pkg::data_t  dout3,

	input  logic            sprite_valid,
	input  logic            bg0_valid,
	input  logic            fl_valid,
	input  logic            cpu_valid,

	output logic            sprite_ready,
	output logic            bg0_ready,
	output logic            fl_ready,
	output logic            cpu_ready,

	output arb_pkg::data_t  sprite_data,
	output arb_pkg::data_t  bg0_data,
	output arb_pkg::data_t  cpu_data
);

	arb_pkg::grant_t grants [`ARB_NUM_BANKS];
	arb_pkg::data_t  douts  [`ARB_NUM_BANKS];

	logic sprite_hit; // some bank belongs to sprite
	logic bg0_hit;
	logic fl_hit;
	logic cpu_hit;

	assign grants = '{grant0, grant1, grant2, grant3};
	assign douts  = '{dout0, dout1, dout2, dout3};

	// a requester holds its address, so at most one bank names it
	always_comb begin
		sprite_hit  = 1'b0;
		bg0_hit     = 1'b0;
		fl_hit      = 1'b0;
		cpu_hit     = 1'b0;
		sprite_data = '0;
		bg0_data    = '0;
		cpu_data    = '0;
		for (int i = 0; i < `ARB_NUM_BANKS; i++) begin
			if (grants[i] == arb_pkg::grant_sprite) begin
				sprite_hit  = 1'b1;
				sprite_data = douts[i];
			end
			if (grants[i] == arb_pkg::grant_bg0) begin
				bg0_hit  = 1'b1;
				bg0_data = douts[i];
			end
			if (grants[i] == arb_pkg::grant_fl)
				fl_hit = 1'b1; // write only, no data back
			if (grants[i] == arb_pkg::grant_cpu) begin
				cpu_hit  = 1'b1;
				cpu_data = douts[i];
			end
		end
	end

	assign sprite_ready = sprite_hit && sprite_valid;
	assign bg0_ready    = bg0_hit && bg0_valid;
	assign fl_ready     = fl_hit && fl_valid;
	assign cpu_ready    = cpu_hit && cpu_valid; // low again once valid drops

endmodule

/* verilog/bank_arbiter.sv */
`timescale 1ns/100ps

`include "arb_params.svh"

module bank_arbiter #(
	parameter int BANK_INDEX = 0
) (
	input  logic               CLK,
	input  logic               RSTb,

	input  logic               sprite_valid,
	input  arb_pkg::addr_t     sprite_address,
	input  logic               bg0_valid,
	input  arb_pkg::addr_t     bg0_address,

	input  logic               fl_valid,
	input  arb_pkg::addr_t     fl_address,
	input  arb_pkg::data_t     fl_data,

	input  logic               cpu_valid,
	input  arb_pkg::addr_t     cpu_address,
	input  logic               cpu_wr,
	input  arb_pkg::mask_t     cpu_wr_mask,
	input  arb_pkg::data_t     cpu_data_in,

	output arb_pkg::grant_t    grant,

	output arb_pkg::bank_addr_t mem_addr,
	output arb_pkg::data_t     mem_din,
	output arb_pkg::mask_t     mem_mask,
	output logic               mem_wr
);

	localparam arb_pkg::bank_sel_t BANK_SEL = arb_pkg::bank_sel_t'(BANK_INDEX);
	localparam arb_pkg::mask_t FULL_MASK = {`ARB_MASK_W{1'b1}};

	arb_pkg::grant_t state;
	arb_pkg::grant_t state_next;

	// request targets this bank
	function automatic logic on_bank(input arb_pkg::addr_t a);
		return a[`ARB_ADDR_W-1 -: `ARB_BANK_SEL_W] == BANK_SEL;
	endfunction

	function automatic arb_pkg::bank_addr_t word_in_bank(input arb_pkg::addr_t a);
		return a[`ARB_BANK_ADDR_W-1:0];
	endfunction

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= arb_pkg::idle;
		end else begin
			state <= state_next;
		end
	end

	// fixed priority, sprite > bg0 > flash > cpu
	always_comb begin
		state_next = state;
		case (state)
			arb_pkg::idle: begin
				if (sprite_valid && on_bank(sprite_address)) begin
					state_next = arb_pkg::grant_sprite;
				end else if (bg0_valid && on_bank(bg0_address)) begin
					state_next = arb_pkg::grant_bg0;
				end else if (fl_valid && on_bank(fl_address)) begin
					state_next = arb_pkg::grant_fl;
				end else if (cpu_valid && on_bank(cpu_address)) begin
					state_next = arb_pkg::grant_cpu;
				end
			end
			arb_pkg::grant_sprite: begin
				if (!sprite_valid)
					state_next = arb_pkg::idle; // owner let go
			end
			arb_pkg::grant_bg0: begin
				if (!bg0_valid)
					state_next = arb_pkg::idle;
			end
			arb_pkg::grant_fl: begin
				if (!fl_valid)
					state_next = arb_pkg::idle;
			end
			arb_pkg::grant_cpu: begin
				if (!cpu_valid)
					state_next = arb_pkg::idle;
			end
			default: state_next = arb_pkg::idle;
		endcase
	end

	// bank port follows the owner
	always_comb begin
		mem_addr = '0;
		mem_din  = '0;
		mem_mask = FULL_MASK; // reads and idle use the whole word
		mem_wr   = 1'b0;
		case (state)
			arb_pkg::grant_sprite: begin
				mem_addr = word_in_bank(sprite_address);
			end
			arb_pkg::grant_bg0: begin
				mem_addr = word_in_bank(bg0_address);
			end
			arb_pkg::grant_fl: begin
				mem_addr = word_in_bank(fl_address);
				mem_din  = fl_data;
				mem_wr   = fl_valid; // stops the cycle valid drops
			end
			arb_pkg::grant_cpu: begin
				mem_addr = word_in_bank(cpu_address);
				mem_din  = cpu_data_in;
				if (cpu_wr)
					mem_mask = cpu_wr_mask; // byte writes
				mem_wr   = cpu_valid && cpu_wr;
			end
			default: ;
		endcase
	end

	assign grant = state;

endmodule

/* verilog/arb_pkg.sv */
`include "arb_params.svh"

package arb_pkg;

	// requester word address, bank in the top bits
	typedef logic [`ARB_ADDR_W-1:0] addr_t;

	typedef logic [`ARB_BANK_ADDR_W-1:0] bank_addr_t; // word within one bank

	typedef logic [`ARB_DATA_W-1:0] data_t;

	// bit 0 low byte, bit 1 high byte
	typedef logic [`ARB_MASK_W-1:0] mask_t;

	typedef logic [`ARB_BANK_SEL_W-1:0] bank_sel_t; // addr[15:14]

	// owner of a bank, one state machine per bank
	typedef enum logic [2:0] {
		idle         = 3'd0,
		grant_sprite = 3'd1,
		grant_bg0    = 3'd2,
		grant_fl     = 3'd3, // flash loader, writes only
		grant_cpu    = 3'd4
	} grant_t;

endpackage

/* verilog/arb_params.svh */
`ifndef ARB_PARAMS_SVH
`define ARB_PARAMS_SVH

// requester side
`define ARB_ADDR_W      16  // word address seen by every requester
`define ARB_DATA_W      16
`define ARB_MASK_W      2   // one enable per byte

// bank side
`define ARB_NUM_BANKS   4
`define ARB_BANK_SEL_W  2   // top address bits pick the bank
`define ARB_BANK_ADDR_W 14  // 16K words per bank

`endif
